//--- core_tile_tests.txt
# W addr data | R addr expected | T slot thread ts locale args abort hold | E
# All fields are hex, text after # is ignored
W 00 00000001                         # start
W 04 00000006                         # dequeue budget
T 1 2 00000100 0010 00050000 0 0
T 3 1 00000101 0010 00070002 0 2      # same locale, one child
T 5 0 00000200 0020 00010003 1 3      # aborted before start
T d 4 00000300 0030 00020001 0 1      # GVT slot, untied child
T 2 7 00000400 0011 00100000 0 0
T 6 3 00000500 0010 00010000 0 0
R 08 00000002                         # enqueues
R 0c 00000006                         # dequeues
R 10 00000500                         # last ts
R 14 00000010                         # last locale
R 18 00000000                         # NEXT_TASK
R 04 00000000                         # budget used up
E

//--- project.f
chronos_pkg.sv
data_mem.sv
app_engine.sv
core_regs.sv
task_core.sv
core_tile.sv
tb_clk_gen.sv
tb_core_tile.sv

//--- Bender.yml
package:
  name: core_tile

sources:
  - chronos_pkg.sv
  - data_mem.sv
  - app_engine.sv
  - core_regs.sv
  - task_core.sv
  - core_tile.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_core_tile.sv

//--- tb_core_tile.sv
`timescale 1ns/10ps

module tb_core_tile import chronos_pkg::*; ();

   logic        clk, rstn;
   logic        task_arvalid, task_rvalid;
   task_t       task_rdata;
   cq_slot_t    task_rslot;
   thread_id_t  task_rthread;
   logic        start_task_valid, start_task_ready;
   cq_slot_t    start_task_slot;
   logic        task_wvalid, task_wready;
   task_t       task_wdata;
   cq_slot_t    task_cq_slot;
   child_id_t   task_child_id;
   logic        task_enq_untied;
   logic        finish_task_valid, finish_task_ready;
   cq_slot_t    finish_task_slot;
   thread_id_t  finish_task_thread;
   child_id_t   finish_task_num_children;
   logic        finish_task_undo_log_write;
   logic        undo_log_valid, undo_log_ready;
   undo_rec_t   undo_log_rec;
   undo_id_t    undo_log_id;
   cq_slot_t    undo_log_slot;
   logic [2**LOG_CQ_SLICE_SIZE-1:0] task_aborted;
   logic        gvt_slot_valid;
   cq_slot_t    gvt_slot;
   logic        reg_wvalid, reg_arvalid, reg_rvalid;
   reg_addr_t   reg_waddr, reg_araddr;
   reg_data_t   reg_wdata, reg_rdata;

   integer    seed = 32'h84ca;
   int        fd;
   int        checks = 0;
   int        errors = 0;
   int        cycles = 0;
   int        cycle_limit = 0;
   string     waiting_for = "reset";
   mem_data_t model_mem [256];

   tb_clk_gen u_clk_gen (
      .clk  (clk),
      .rstn (rstn)
   );

   core_tile dut (.*);

   always @(posedge clk) begin
      cycles = cycles + 1;
      if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
         errors = errors + 1;
         $display("ERROR: timeout after %0d cycles while waiting for %s", cycles, waiting_for);
         $display("checks: %0d  errors: %0d", checks, errors);
         $display("*** FAILED ***");
         $finish;
      end
   end

   task automatic check_val(input string name, input logic [127:0] got,
                            input logic [127:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("CHECK FAILED %s: got %0h expected %0h", name, got, expected);
      end
   endtask

   // Skips blanks and returns the first character of the next token
   task automatic read_op(output int c);
      c = $fgetc(fd);
      while ((c == " ") || (c == "\n") || (c == "\t") || (c == "\r")) begin
         c = $fgetc(fd);
      end
   endtask

   task automatic skip_line();
      int c;
      c = $fgetc(fd);
      while ((c != "\n") && (c != -1)) begin
         c = $fgetc(fd);
      end
   endtask

   task automatic count_tasks(output int n);
      int c;
      n = 0;
      read_op(c);
      while (c != -1) begin
         if (c == "T") begin
            n++;
         end
         skip_line();
         read_op(c);
      end
   endtask

   task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
      reg_wvalid = 1'b1;
      reg_waddr  = addr;
      reg_wdata  = data;
      @(negedge clk);
      reg_wvalid = 1'b0;
   endtask

   task automatic reg_read(input reg_addr_t addr, input reg_data_t expected);
      reg_arvalid = 1'b1;
      reg_araddr  = addr;
      @(negedge clk);
      reg_arvalid = 1'b0;
      check_val("reg_rvalid", reg_rvalid, 1'b1);
      check_val("reg_rdata", reg_rdata, expected);
   endtask

   task automatic run_task(input cq_slot_t slot, input thread_id_t thr, input ts_t ts,
                           input locale_t loc, input args_t args, input logic abort,
                           input int hold);
      task_t     cur, exp_child, enq_saved;
      undo_rec_t exp_undo, undo_saved;
      mem_data_t old;
      child_id_t exp_children;
      logic      has_child, untied, done;
      logic      enq_stall, undo_stall, fin_stall;
      int        exp_n_undo, exp_n_enq, n_undo, n_enq, hold_left;

      cur.ts     = ts;
      cur.locale = loc;
      cur.ttype  = thr;
      cur.args   = args;
      old = model_mem[loc[7:0]];
      exp_undo.addr = loc[7:0];
      exp_undo.data = old;
      has_child = (args[3:0] != 4'd0);
      untied    = has_child && gvt_slot_valid && (gvt_slot == slot);
      exp_child.ts     = ts + 32'd1;
      exp_child.locale = loc + 16'd1;
      exp_child.ttype  = thr;
      exp_child.args   = {args[31:4], args[3:0] - 4'd1};
      // An aborted task never reaches the engine
      if (abort) begin
         exp_n_undo   = 0;
         exp_n_enq    = 0;
         exp_children = 4'd0;
      end else begin
         model_mem[loc[7:0]] = old + {16'h0000, args[31:16]};
         exp_n_undo   = 1;
         exp_n_enq    = has_child ? 1 : 0;
         exp_children = (has_child && !untied) ? 4'd1 : 4'd0;
      end

      waiting_for = "task dequeue";
      while (!task_arvalid) begin
         @(negedge clk);
      end
      task_rvalid  = 1'b1;
      task_rdata   = cur;
      task_rslot   = slot;
      task_rthread = thr;
      @(negedge clk);
      task_rvalid = 1'b0;
      check_val("start_task_valid", start_task_valid, 1'b1);
      check_val("start_task_slot", start_task_slot, slot);
      if (abort) begin
         task_aborted[slot] = 1'b1;
      end

      hold_left  = hold;
      n_undo     = 0;
      n_enq      = 0;
      done       = 1'b0;
      enq_stall  = 1'b0;
      undo_stall = 1'b0;
      fin_stall  = 1'b0;
      waiting_for = "finish report";
      while (!done) begin
         // Outputs that were stalled last cycle must not move
         if (enq_stall) begin
            check_val("task_wvalid", task_wvalid, 1'b1);
            check_val("task_wdata", task_wdata, enq_saved);
         end
         if (undo_stall) begin
            check_val("undo_log_valid", undo_log_valid, 1'b1);
            check_val("undo_log_rec", undo_log_rec, undo_saved);
         end
         if (fin_stall) begin
            check_val("finish_task_valid", finish_task_valid, 1'b1);
         end
         start_task_ready  = ($random(seed) & 3) != 0;
         task_wready       = ($random(seed) & 3) != 0;
         undo_log_ready    = ($random(seed) & 3) != 0;
         finish_task_ready = ($random(seed) & 3) != 0;
         if (start_task_valid && (hold_left > 0)) begin
            start_task_ready = 1'b0;
            hold_left--;
         end
         if (task_wvalid && task_wready) begin
            n_enq++;
            check_val("task_wdata", task_wdata, exp_child);
            check_val("task_cq_slot", task_cq_slot, slot);
            check_val("task_child_id", task_child_id, 4'd0);
            check_val("task_enq_untied", task_enq_untied, untied);
         end
         if (undo_log_valid && undo_log_ready) begin
            n_undo++;
            check_val("undo_log_rec", undo_log_rec, exp_undo);
            check_val("undo_log_id", undo_log_id, 4'd0);
            check_val("undo_log_slot", undo_log_slot, slot);
         end
         if (finish_task_valid && finish_task_ready) begin
            check_val("finish_task_slot", finish_task_slot, slot);
            check_val("finish_task_thread", finish_task_thread, thr);
            check_val("finish_task_num_children", finish_task_num_children, exp_children);
            check_val("finish_task_undo_log_write", finish_task_undo_log_write, !abort);
            done = 1'b1;
         end
         enq_stall  = task_wvalid && !task_wready;
         enq_saved  = task_wdata;
         undo_stall = undo_log_valid && !undo_log_ready;
         undo_saved = undo_log_rec;
         fin_stall  = finish_task_valid && !finish_task_ready;
         @(negedge clk);
      end

      start_task_ready  = 1'b0;
      task_wready       = 1'b0;
      undo_log_ready    = 1'b0;
      finish_task_ready = 1'b0;
      task_aborted      = '0;
      if (n_undo != exp_n_undo) begin
         errors++;
         $display("ERROR: task in slot %0h gave %0d undo records instead of %0d",
                  slot, n_undo, exp_n_undo);
      end
      if (n_enq != exp_n_enq) begin
         errors++;
         $display("ERROR: task in slot %0h gave %0d enqueues instead of %0d",
                  slot, n_enq, exp_n_enq);
      end
   endtask

   initial begin
      int          op, n, n_tasks;
      logic [31:0] fld [0:6];
      logic        finished;

      task_rvalid       = 1'b0;
      task_rdata        = '0;
      task_rslot        = '0;
      task_rthread      = '0;
      start_task_ready  = 1'b0;
      task_wready       = 1'b0;
      finish_task_ready = 1'b0;
      undo_log_ready    = 1'b0;
      task_aborted      = '0;
      gvt_slot_valid    = 1'b1;
      gvt_slot          = 4'hd;
      reg_wvalid        = 1'b0;
      reg_waddr         = '0;
      reg_wdata         = '0;
      reg_arvalid       = 1'b0;
      reg_araddr        = '0;
      for (int i = 0; i < 256; i++) begin
         model_mem[i] = '0;
      end

      fd = $fopen("core_tile_tests.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("ERROR: cannot open core_tile_tests.txt");
      end else begin
         count_tasks(n_tasks);
         $fclose(fd);
         cycle_limit = 400 * n_tasks + 1000;
         fd = $fopen("core_tile_tests.txt", "r");
         wait (rstn);
         @(negedge clk);
         finished = 1'b0;
         while (!finished) begin
            read_op(op);
            if (op == -1) begin
               errors++;
               $display("ERROR: test file ended without an end record");
               finished = 1'b1;
            end else begin
               case (op)
                  "#": skip_line();
                  "W": begin
                     n = $fscanf(fd, "%h %h", fld[0], fld[1]);
                     if (n == 2) begin
                        waiting_for = "register write";
                        reg_write(fld[0][7:0], fld[1]);
                     end
                  end
                  "R": begin
                     n = $fscanf(fd, "%h %h", fld[0], fld[1]);
                     if (n == 2) begin
                        waiting_for = "register read";
                        reg_read(fld[0][7:0], fld[1]);
                     end
                  end
                  "T": begin
                     n = $fscanf(fd, "%h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                                 fld[3], fld[4], fld[5], fld[6]);
                     if (n == 7) begin
                        run_task(fld[0][3:0], fld[1][3:0], fld[2], fld[3][15:0], fld[4],
                                 fld[5][0], int'(fld[6]));
                     end
                  end
                  "E": begin
                     // Budget is used up, so no further dequeue may be requested
                     waiting_for = "idle check";
                     n = 0;
                     repeat (20) begin
                        check_val("task_arvalid", task_arvalid, 1'b0);
                        @(negedge clk);
                     end
                     finished = 1'b1;
                  end
                  default: begin
                     n = -1;
                     errors++;
                     $display("ERROR: unknown record type in test file");
                     finished = 1'b1;
                  end
               endcase
               if ((op == "W" && n != 2) || (op == "R" && n != 2) || (op == "T" && n != 7)) begin
                  errors++;
                  $display("ERROR: malformed record in test file");
                  finished = 1'b1;
               end
            end
         end
         $fclose(fd);
      end

      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Reset held for 16 rising edges, released away from the active edge
   initial begin
      rstn = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
   end

endmodule

//--- core_tile.sv
`timescale 1ns/10ps

module core_tile import chronos_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   output logic        task_arvalid,
   input  logic        task_rvalid,
   input  task_t       task_rdata,
   input  cq_slot_t    task_rslot,
   input  thread_id_t  task_rthread,
   output logic        start_task_valid,
   input  logic        start_task_ready,
   output cq_slot_t    start_task_slot,
   output logic        task_wvalid,
   input  logic        task_wready,
   output task_t       task_wdata,
   output cq_slot_t    task_cq_slot,
   output child_id_t   task_child_id,
   output logic        task_enq_untied,
   output logic        finish_task_valid,
   input  logic        finish_task_ready,
   output cq_slot_t    finish_task_slot,
   output thread_id_t  finish_task_thread,
   output child_id_t   finish_task_num_children,
   output logic        finish_task_undo_log_write,
   output logic        undo_log_valid,
   input  logic        undo_log_ready,
   output undo_rec_t   undo_log_rec,
   output undo_id_t    undo_log_id,
   output cq_slot_t    undo_log_slot,
   input  logic [2**LOG_CQ_SLICE_SIZE-1:0] task_aborted,
   input  logic        gvt_slot_valid,
   input  cq_slot_t    gvt_slot,
   input  logic        reg_wvalid,
   input  reg_addr_t   reg_waddr,
   input  reg_data_t   reg_wdata,
   input  logic        reg_arvalid,
   input  reg_addr_t   reg_araddr,
   output logic        reg_rvalid,
   output reg_data_t   reg_rdata
);

   logic        ap_start, ap_rstn, ap_done, ap_idle;
   task_t       ap_task;
   logic        child_valid, child_ready;
   task_t       child_task;
   logic        undo_valid, undo_ready;
   undo_rec_t   undo_rec;
   logic        mem_req_valid;
   mem_req_t    mem_req;
   logic        mem_rvalid, mem_bvalid;
   mem_data_t   mem_rdata;
   logic        mem_gate;
   logic        eng_rvalid, eng_bvalid;
   core_state_t core_state;
   logic        start_en, budget_ok;
   logic        deq_fire, enq_fire;

   assign deq_fire   = task_arvalid & task_rvalid;
   assign enq_fire   = task_wvalid & task_wready;
   assign eng_rvalid = mem_rvalid & !mem_gate;
   assign eng_bvalid = mem_bvalid & !mem_gate;

   task_core u_task_core (.*);

   app_engine u_app_engine (
      .*,
      .mem_rvalid (eng_rvalid),
      .mem_bvalid (eng_bvalid)
   );

   core_regs u_core_regs (
      .*,
      .cur_task (ap_task)
   );

   data_mem u_data_mem (.*);

endmodule

//--- task_core.sv
`timescale 1ns/10ps

module task_core import chronos_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   output logic        task_arvalid,
   input  logic        task_rvalid,
   input  task_t       task_rdata,
   input  cq_slot_t    task_rslot,
   input  thread_id_t  task_rthread,
   output logic        start_task_valid,
   input  logic        start_task_ready,
   output cq_slot_t    start_task_slot,
   output logic        task_wvalid,
   input  logic        task_wready,
   output task_t       task_wdata,
   output cq_slot_t    task_cq_slot,
   output child_id_t   task_child_id,
   output logic        task_enq_untied,
   output logic        finish_task_valid,
   input  logic        finish_task_ready,
   output cq_slot_t    finish_task_slot,
   output thread_id_t  finish_task_thread,
   output child_id_t   finish_task_num_children,
   output logic        finish_task_undo_log_write,
   output logic        undo_log_valid,
   input  logic        undo_log_ready,
   output undo_rec_t   undo_log_rec,
   output undo_id_t    undo_log_id,
   output cq_slot_t    undo_log_slot,
   input  logic [2**LOG_CQ_SLICE_SIZE-1:0] task_aborted,
   input  logic        gvt_slot_valid,
   input  cq_slot_t    gvt_slot,
   input  logic        start_en,
   input  logic        budget_ok,
   output logic        ap_start,
   output task_t       ap_task,
   output logic        ap_rstn,
   input  logic        ap_done,
   input  logic        ap_idle,
   input  logic        child_valid,
   output logic        child_ready,
   input  task_t       child_task,
   input  logic        undo_valid,
   output logic        undo_ready,
   input  undo_rec_t   undo_rec,
   input  logic        mem_req_valid,
   input  mem_req_t    mem_req,
   input  logic        mem_rvalid,
   input  logic        mem_bvalid,
   output logic        mem_gate,
   output core_state_t core_state
);

   core_state_t state, state_next;
   cq_slot_t    cq_slot;
   thread_id_t  thread_id;
   child_id_t   child_id;
   logic        deq_fire, fin_fire;
   logic        abort_hit, abort_q;
   logic [2:0]  abort_cnt;
   logic [2:0]  reads_left, writes_left;

   assign deq_fire = task_arvalid & task_rvalid;
   assign fin_fire = finish_task_valid & finish_task_ready;

   assign task_arvalid      = (state == NEXT_TASK) & start_en & budget_ok & ap_rstn;
   assign start_task_valid  = (state == INFORM_CQ);
   assign finish_task_valid = (state == FINISH_TASK) & !task_wvalid & !undo_log_valid;
   assign ap_start          = (state == START_CORE);
   assign core_state        = state;

   assign start_task_slot  = cq_slot;
   assign finish_task_slot = cq_slot;
   assign task_cq_slot     = cq_slot;
   assign undo_log_slot    = cq_slot;
   assign finish_task_thread       = thread_id;
   assign finish_task_num_children = child_id;
   assign task_child_id            = child_id;

   // Abort only counts while the task is between dequeue and engine done
   assign abort_hit = task_aborted[cq_slot] &
                      ((state == INFORM_CQ) | ((state == WAIT_CORE) & !ap_done));

   // Responses for an aborted or finished task must not reach the engine
   assign mem_gate = abort_q | (state inside {FINISH_TASK, WAIT_BVALID, WAIT_RVALID});

   always_ff @(posedge clk) begin
      if (deq_fire) begin
         cq_slot   <= task_rslot;
         thread_id <= task_rthread;
         ap_task   <= task_rdata;
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         NEXT_TASK: if (deq_fire) state_next = INFORM_CQ;
         INFORM_CQ: begin
            if (start_task_ready) begin
               state_next = (abort_q | abort_hit) ? FINISH_TASK : START_CORE;
            end
         end
         START_CORE: state_next = WAIT_CORE;
         WAIT_CORE: begin
            if (ap_done) begin
               state_next = FINISH_TASK;
            end else if (abort_hit) begin
               state_next = ABORT_TASK;
            end
         end
         ABORT_TASK: begin
            if ((abort_cnt == 3'(ABORT_RST_CYCLES)) & ap_rstn & ap_idle) begin
               state_next = FINISH_TASK;
            end
         end
         FINISH_TASK: begin
            if (fin_fire) begin
               state_next = ((reads_left != '0) | (writes_left != '0)) ? WAIT_BVALID : NEXT_TASK;
            end
         end
         WAIT_BVALID: if (writes_left == '0) state_next = WAIT_RVALID;
         WAIT_RVALID: if (reads_left == '0) state_next = NEXT_TASK;
         default: state_next = NEXT_TASK;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state   <= NEXT_TASK;
         abort_q <= 1'b0;
      end else begin
         state <= state_next;
         if (fin_fire) begin
            abort_q <= 1'b0;
         end else if (abort_hit) begin
            abort_q <= 1'b1;
         end
      end
   end

   // Engine reset is held low for ABORT_RST_CYCLES after entering ABORT_TASK
   always_ff @(posedge clk) begin
      if (!rstn) begin
         abort_cnt <= '0;
         ap_rstn   <= 1'b0;
      end else if (state == ABORT_TASK) begin
         if (abort_cnt != 3'(ABORT_RST_CYCLES)) begin
            abort_cnt <= abort_cnt + 3'd1;
         end
         ap_rstn <= (abort_cnt == 3'(ABORT_RST_CYCLES));
      end else begin
         abort_cnt <= '0;
         ap_rstn   <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reads_left  <= '0;
         writes_left <= '0;
      end else begin
         reads_left  <= reads_left + 3'(mem_req_valid & !mem_req.we) - 3'(mem_rvalid);
         writes_left <= writes_left + 3'(mem_req_valid & mem_req.we) - 3'(mem_bvalid);
      end
   end

   // Enqueue buffer, emptied on abort
   assign child_ready = !task_wvalid & (state != ABORT_TASK);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_wvalid <= 1'b0;
      end else if (state == ABORT_TASK) begin
         task_wvalid <= 1'b0;
      end else if (child_valid & child_ready) begin
         task_wvalid <= 1'b1;
      end else if (task_wready) begin
         task_wvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (child_valid & child_ready) begin
         task_wdata      <= child_task;
         task_enq_untied <= gvt_slot_valid & (gvt_slot == cq_slot);
      end
   end

   // Untied children are not reported in the child count
   always_ff @(posedge clk) begin
      if (!rstn) begin
         child_id <= '0;
      end else if (deq_fire) begin
         child_id <= '0;
      end else if (task_wvalid & task_wready & !task_enq_untied) begin
         child_id <= child_id + 4'd1;
      end
   end

   assign undo_ready = !undo_log_valid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         undo_log_valid <= 1'b0;
      end else if (undo_valid & undo_ready) begin
         undo_log_valid <= 1'b1;
      end else if (undo_log_ready) begin
         undo_log_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (undo_valid & undo_ready) begin
         undo_log_rec <= undo_rec;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         undo_log_id                <= '0;
         finish_task_undo_log_write <= 1'b0;
      end else begin
         if (fin_fire) begin
            undo_log_id <= '0;
         end else if (undo_log_valid & undo_log_ready) begin
            undo_log_id <= undo_log_id + 4'd1;
         end
         if (deq_fire) begin
            finish_task_undo_log_write <= 1'b0;
         end else if (undo_valid & undo_ready) begin
            finish_task_undo_log_write <= 1'b1;
         end
      end
   end

   // The engine must stay quiet while the finish report waits
   a_fin_hold: assert property (@(posedge clk) disable iff (!rstn)
      finish_task_valid && !finish_task_ready |=> finish_task_valid);

   // A pending enqueue is only ever withdrawn by an abort
   a_enq_hold: assert property (@(posedge clk) disable iff (!rstn)
      task_wvalid && !task_wready && (state != ABORT_TASK)
      |=> task_wvalid && $stable(task_wdata));

endmodule

//--- core_regs.sv
`timescale 1ns/10ps

module core_regs import chronos_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   input  logic        reg_wvalid,
   input  reg_addr_t   reg_waddr,
   input  reg_data_t   reg_wdata,
   input  logic        reg_arvalid,
   input  reg_addr_t   reg_araddr,
   output logic        reg_rvalid,
   output reg_data_t   reg_rdata,
   input  logic        deq_fire,
   input  logic        enq_fire,
   input  task_t       cur_task,
   input  core_state_t core_state,
   output logic        start_en,
   output logic        budget_ok
);

   reg_data_t budget;
   reg_data_t num_enq;
   reg_data_t num_deq;

   assign budget_ok = (budget != '0);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         start_en <= 1'b0;
         budget   <= '1;
         num_enq  <= '0;
         num_deq  <= '0;
      end else begin
         if (reg_wvalid && (reg_waddr == CORE_START)) begin
            start_en <= reg_wdata[0];
         end
         if (reg_wvalid && (reg_waddr == CORE_N_DEQUEUES)) begin
            budget <= reg_wdata;
         end else if (deq_fire) begin
            budget <= budget - 32'd1;
         end
         num_enq <= num_enq + 32'(enq_fire);
         num_deq <= num_deq + 32'(deq_fire);
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_arvalid) begin
         case (reg_araddr)
            CORE_START:      reg_rdata <= 32'(start_en);
            CORE_N_DEQUEUES: reg_rdata <= budget;
            CORE_NUM_ENQ:    reg_rdata <= num_enq;
            CORE_NUM_DEQ:    reg_rdata <= num_deq;
            CORE_TS:         reg_rdata <= cur_task.ts;
            CORE_LOCALE:     reg_rdata <= 32'(cur_task.locale);
            CORE_STATE:      reg_rdata <= 32'(core_state);
            default:         reg_rdata <= '0;
         endcase
      end
   end

   a_deq_in_budget: assert property (@(posedge clk) disable iff (!rstn)
      deq_fire |-> budget_ok && start_en);

endmodule

//--- app_engine.sv
`timescale 1ns/10ps

module app_engine import chronos_pkg::*; (
   input  logic      clk,
   input  logic      ap_rstn,
   input  logic      ap_start,
   input  task_t     ap_task,
   output logic      ap_done,
   output logic      ap_idle,
   output logic      child_valid,
   input  logic      child_ready,
   output task_t     child_task,
   output logic      undo_valid,
   input  logic      undo_ready,
   output undo_rec_t undo_rec,
   output logic      mem_req_valid,
   output mem_req_t  mem_req,
   input  logic      mem_rvalid,
   input  mem_data_t mem_rdata,
   input  logic      mem_bvalid
);

   typedef enum logic [2:0] {
      E_IDLE, E_READ, E_RWAIT, E_UNDO,
      E_WRITE, E_BWAIT, E_CHILD, E_DONE
   } eng_state_t;

   eng_state_t state;
   task_t      job;
   mem_data_t  old_data;
   mem_addr_t  addr;
   logic       has_child;

   assign addr      = job.locale[7:0];
   assign has_child = (job.args[3:0] != 4'd0);

   always_ff @(posedge clk) begin
      if (!ap_rstn) begin
         state <= E_IDLE;
      end else begin
         case (state)
            E_IDLE:  if (ap_start) state <= E_READ;
            E_READ:  state <= E_RWAIT;
            E_RWAIT: if (mem_rvalid) state <= E_UNDO;
            // Undo record must be accepted before the word is overwritten
            E_UNDO:  if (undo_ready) state <= E_WRITE;
            E_WRITE: state <= E_BWAIT;
            E_BWAIT: if (mem_bvalid) state <= has_child ? E_CHILD : E_DONE;
            E_CHILD: if (child_ready) state <= E_DONE;
            default: state <= E_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ap_start && (state == E_IDLE)) begin
         job <= ap_task;
      end
      if (mem_rvalid && (state == E_RWAIT)) begin
         old_data <= mem_rdata;
      end
   end

   assign ap_idle = (state == E_IDLE);
   assign ap_done = (state == E_DONE);

   assign mem_req_valid = (state == E_READ) | (state == E_WRITE);
   assign mem_req.we    = (state == E_WRITE);
   assign mem_req.addr  = addr;
   assign mem_req.wdata = old_data + mem_data_t'(job.args[31:16]);

   assign undo_valid    = (state == E_UNDO);
   assign undo_rec.addr = addr;
   assign undo_rec.data = old_data;

   // Child works on the next locale with one less step to go
   assign child_valid       = (state == E_CHILD);
   assign child_task.ts     = job.ts + 32'd1;
   assign child_task.locale = job.locale + 16'd1;
   assign child_task.ttype  = job.ttype;
   assign child_task.args   = {job.args[31:4], job.args[3:0] - 4'd1};

endmodule

//--- data_mem.sv
`timescale 1ns/10ps

module data_mem import chronos_pkg::*; (
   input  logic      clk,
   input  logic      mem_req_valid,
   input  mem_req_t  mem_req,
   output logic      mem_rvalid,
   output mem_data_t mem_rdata,
   output logic      mem_bvalid
);

   mem_data_t mem [256] = '{default: '0};

   always_ff @(posedge clk) begin
      if (mem_req_valid && mem_req.we) begin
         mem[mem_req.addr] <= mem_req.wdata;
      end
      if (mem_req_valid && !mem_req.we) begin
         mem_rdata <= mem[mem_req.addr];
      end
   end

   // Read data and write acknowledge both come back on the next cycle
   always_ff @(posedge clk) begin
      mem_rvalid <= mem_req_valid & !mem_req.we;
      mem_bvalid <= mem_req_valid & mem_req.we;
   end

endmodule

//--- chronos_pkg.sv
package chronos_pkg;

   // Queue slice geometry
   localparam int LOG_CQ_SLICE_SIZE = 4;

   // Engine reset length after an abort, in cycles
   localparam int ABORT_RST_CYCLES = 6;

   typedef logic [31:0] ts_t;
   typedef logic [15:0] locale_t;
   typedef logic [3:0]  ttype_t;
   typedef logic [31:0] args_t;

   typedef struct packed {
      ts_t     ts;
      locale_t locale;
      ttype_t  ttype;
      args_t   args;
   } task_t;

   typedef logic [LOG_CQ_SLICE_SIZE-1:0] cq_slot_t;
   typedef logic [3:0] thread_id_t;
   typedef logic [3:0] child_id_t;
   typedef logic [3:0] undo_id_t;

   typedef logic [7:0]  mem_addr_t;
   typedef logic [31:0] mem_data_t;

   // Old contents of a word, logged before it is overwritten
   typedef struct packed {
      mem_addr_t addr;
      mem_data_t data;
   } undo_rec_t;

   typedef struct packed {
      logic      we;
      mem_addr_t addr;
      mem_data_t wdata;
   } mem_req_t;

   typedef enum logic [2:0] {
      NEXT_TASK, INFORM_CQ,
      START_CORE, WAIT_CORE,
      ABORT_TASK, FINISH_TASK,
      WAIT_BVALID, WAIT_RVALID
   } core_state_t;

   typedef logic [7:0]  reg_addr_t;
   typedef logic [31:0] reg_data_t;

   localparam reg_addr_t CORE_START      = 8'h00;
   localparam reg_addr_t CORE_N_DEQUEUES = 8'h04;
   localparam reg_addr_t CORE_NUM_ENQ    = 8'h08;
   localparam reg_addr_t CORE_NUM_DEQ    = 8'h0c;
   localparam reg_addr_t CORE_TS         = 8'h10;
   localparam reg_addr_t CORE_LOCALE     = 8'h14;
   localparam reg_addr_t CORE_STATE      = 8'h18;

endpackage
